// File: Bender.yml
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/fetch_unit.sv
  - source/decode_unit.sv
  - source/reg_file.sv
  - source/execute_unit.sv
  - source/mem_stage.sv
  - source/rv_core.sv
  - target: simulation
    files:
      - verification/rv_core_props.sv
      - verification/rv_core_tb.sv

// File: sim.f
source/rv_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/mem_stage.sv
source/rv_core.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

// File: source/decode_unit.sv
`default_nettype none

module decode_unit (
  input  rv_pkg::inst_u     inst,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              alu_src_imm,
  output logic              alu_a_pc,
  output logic              rd_we_req,
  output logic              mem_read,
  output logic              mem_write,
  output logic              mem_byte,
  output logic              branch,
  output logic              jump,
  output logic              jalr,
  output rv_pkg::branch_t   br_kind,
  output rv_pkg::wb_sel_t   wb_src
);
  import rv_pkg::*;

  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t f3_op;
  logic alt_sub;

  // register fields sit in the same place in every format
  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;
  assign rd = inst.r.rd;
  assign br_kind = branch_t'(inst.b.funct3);

  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign imm_u = {inst.u.imm20, 12'd0};
  assign imm_j = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};

  assign alt_sub = (inst.r.opcode == OP_REG) && inst.r.funct7[5]; // no subi

  always_comb begin
    case (inst.r.funct3)
      3'b000: f3_op = alt_sub ? ALU_SUB : ALU_ADD;
      3'b001: f3_op = ALU_SLL;
      3'b010: f3_op = ALU_SLT;
      3'b011: f3_op = ALU_SLTU;
      3'b100: f3_op = ALU_XOR;
      3'b101: f3_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL; // srai has the same bit
      3'b110: f3_op = ALU_OR;
      default: f3_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm = '0;
    alu_op = ALU_ADD;
    alu_src_imm = 1'b0;
    alu_a_pc = 1'b0;
    rd_we_req = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    mem_byte = 1'b0;
    branch = 1'b0;
    jump = 1'b0;
    jalr = 1'b0;
    wb_src = WB_ALU;
    case (inst.r.opcode)
      OP_REG: begin
        alu_op = f3_op;
        rd_we_req = 1'b1;
      end
      OP_IMM: begin
        alu_op = f3_op;
        imm = imm_i;
        alu_src_imm = 1'b1;
        rd_we_req = 1'b1;
      end
      OP_LOAD: begin
        if (inst.i.funct3 == F3_BYTE || inst.i.funct3 == F3_WORD) begin
          imm = imm_i;
          alu_src_imm = 1'b1;
          mem_read = 1'b1;
          mem_byte = (inst.i.funct3 == F3_BYTE);
          rd_we_req = 1'b1;
          wb_src = WB_MEM;
        end
      end
      OP_STORE: begin
        if (inst.s.funct3 == F3_BYTE || inst.s.funct3 == F3_WORD) begin
          imm = imm_s;
          alu_src_imm = 1'b1;
          mem_write = 1'b1;
          mem_byte = (inst.s.funct3 == F3_BYTE);
        end
      end
      OP_BRANCH: begin
        imm = imm_b;
        branch = 1'b1;
      end
      OP_LUI: begin
        imm = imm_u;
        alu_op = ALU_PASS_B;
        alu_src_imm = 1'b1;
        rd_we_req = 1'b1;
      end
      OP_AUIPC: begin
        imm = imm_u;
        alu_a_pc = 1'b1;
        alu_src_imm = 1'b1;
        rd_we_req = 1'b1;
      end
      OP_JAL: begin
        imm = imm_j;
        jump = 1'b1;
        rd_we_req = 1'b1;
        wb_src = WB_LINK;
      end
      OP_JALR: begin
        imm = imm_i;
        jalr = 1'b1;
        rd_we_req = 1'b1;
        wb_src = WB_LINK;
      end
      default: ; // unknown opcode acts as nop
    endcase
  end

endmodule

`default_nettype wire

// File: source/execute_unit.sv
`default_nettype none

module execute_unit (
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::word_t   pc,
  input  rv_pkg::alu_op_t alu_op,
  input  logic            alu_src_imm,
  input  logic            alu_a_pc,
  input  logic            branch,
  input  rv_pkg::branch_t br_kind,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);
  import rv_pkg::*;

  word_t op_a, op_b;
  logic [4:0] shamt;
  logic cond;

  assign op_a = alu_a_pc ? pc : rs1_data;
  assign op_b = alu_src_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_AND:    result = op_a & op_b;
      ALU_OR:     result = op_a | op_b;
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {31'd0, op_a < op_b};
      ALU_PASS_B: result = op_b; // lui
      default:    result = '0;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    case (br_kind)
      BR_EQ:   cond = (rs1_data == rs2_data);
      BR_NE:   cond = (rs1_data != rs2_data);
      BR_LT:   cond = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   cond = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  cond = (rs1_data < rs2_data);
      BR_GEU:  cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = branch && cond;

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none

module fetch_unit (
  input  logic          clk,
  input  logic          rst,
  input  logic          stall,
  input  logic          branch_taken,
  input  logic          jump,
  input  logic          jalr,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t target_base,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);
  import rv_pkg::*;

  word_t next_pc;
  word_t jalr_target;

  assign pc_plus4 = pc + 32'd4;
  assign jalr_target = target_base + imm;

  always_comb begin
    if (jalr) begin
      next_pc = {jalr_target[31:1], 1'b0}; // bit 0 dropped per spec
    end else if (branch_taken || jump) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= next_pc; // held while data access waits
    end
  end

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`default_nettype none

module mem_stage (
  input  logic            mem_read,
  input  logic            mem_write,
  input  logic            mem_byte,
  input  logic            rd_we_req,
  input  rv_pkg::wb_sel_t wb_src,
  input  rv_pkg::word_t   alu_result,
  input  rv_pkg::word_t   store_data,
  input  rv_pkg::word_t   pc_plus4,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output rv_pkg::word_t   wb_adr,
  output rv_pkg::word_t   wb_dat_w,
  output logic [3:0]      wb_sel,
  input  rv_pkg::word_t   wb_dat_r,
  input  logic            wb_ack,
  output logic            stall,
  output logic            rd_we,
  output rv_pkg::word_t   rd_data
);
  import rv_pkg::*;

  logic access;
  logic [7:0] lane;
  word_t load_data;

  assign access = mem_read || mem_write;

  // classic cycle, held until ack
  assign wb_cyc = access;
  assign wb_stb = access;
  assign wb_we = mem_write;
  assign wb_adr = {alu_result[31:2], 2'b00};
  assign wb_dat_w = mem_byte ? {4{store_data[7:0]}} : store_data;
  assign wb_sel = mem_byte ? (4'b0001 << alu_result[1:0]) : 4'b1111;

  assign stall = access && !wb_ack;

  always_comb begin
    case (alu_result[1:0])
      2'd0:    lane = wb_dat_r[7:0];
      2'd1:    lane = wb_dat_r[15:8];
      2'd2:    lane = wb_dat_r[23:16];
      default: lane = wb_dat_r[31:24];
    endcase
  end

  assign load_data = mem_byte ? {{24{lane[7]}}, lane} : wb_dat_r; // lb sign-extends

  always_comb begin
    case (wb_src)
      WB_MEM:  rd_data = load_data;
      WB_LINK: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  assign rd_we = rd_we_req && !stall; // loads write on the ack edge

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  logic              rd_we,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [1:31]; // x0 has no storage

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output logic          wb_cyc,
  output logic          wb_stb,
  output logic          wb_we,
  output rv_pkg::word_t wb_adr,
  output rv_pkg::word_t wb_dat_w,
  output logic [3:0]    wb_sel,
  input  rv_pkg::word_t wb_dat_r,
  input  logic          wb_ack
);
  import rv_pkg::*;

  inst_u inst;
  reg_addr_t rs1, rs2, rd;
  word_t imm, pc_plus4, rs1_data, rs2_data, result, rd_data;
  alu_op_t alu_op;
  branch_t br_kind;
  wb_sel_t wb_src;
  logic alu_src_imm, alu_a_pc, rd_we_req, mem_read, mem_write, mem_byte;
  logic branch, jump, jalr, branch_taken, stall, rd_we;

  assign inst = imem_data;

  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .stall(stall), .branch_taken(branch_taken),
    .jump(jump), .jalr(jalr), .imm(imm), .target_base(rs1_data),
    .pc(imem_addr), .pc_plus4(pc_plus4)
  );

  decode_unit u_decode (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .alu_src_imm(alu_src_imm), .alu_a_pc(alu_a_pc), .rd_we_req(rd_we_req),
    .mem_read(mem_read), .mem_write(mem_write), .mem_byte(mem_byte),
    .branch(branch), .jump(jump), .jalr(jalr), .br_kind(br_kind), .wb_src(wb_src)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .rs1_addr(rs1), .rs2_addr(rs2), .rd_addr(rd),
    .rd_we(rd_we), .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  execute_unit u_exec (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(imem_addr),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .alu_a_pc(alu_a_pc),
    .branch(branch), .br_kind(br_kind), .result(result), .branch_taken(branch_taken)
  );

  mem_stage u_mem (
    .mem_read(mem_read), .mem_write(mem_write), .mem_byte(mem_byte),
    .rd_we_req(rd_we_req), .wb_src(wb_src), .alu_result(result),
    .store_data(rs2_data), .pc_plus4(pc_plus4), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .stall(stall), .rd_we(rd_we),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

  localparam logic [2:0] F3_BYTE = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_AND,
    ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_t;

  // values match branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_t;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0] rd;
    logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20;
    logic [9:0] imm10_1;
    logic imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

`default_nettype wire

// File: verification/rv_core_props.sv
`default_nettype none

module rv_core_props (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t imem_addr,
  input logic          wb_cyc,
  input logic          wb_stb,
  input logic          wb_we,
  input rv_pkg::word_t wb_adr,
  input rv_pkg::word_t wb_dat_w,
  input logic [3:0]    wb_sel,
  input logic          wb_ack
);
  timeunit 1ns;
  timeprecision 100ps;

  int err_count = 0; // failures seen so far

  reset_idle: assert property (@(posedge clk)
    (rst || $fell(rst)) |-> (imem_addr == '0 && !wb_cyc && !wb_stb))
    else begin
      err_count++;
      $error("fetch or bus active in or right after reset");
    end

  // request held until ack
  hold_req: assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_dat_w)
      && $stable(wb_sel) && $stable(wb_we) && $stable(imem_addr)))
    else begin
      err_count++;
      $error("request or fetch address changed before ack");
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
    else begin
      err_count++;
      $error("ack without stb");
    end

endmodule

bind rv_core rv_core_props props (.*);

`default_nettype wire

// File: verification/rv_core_tb.sv
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  logic clk;
  logic rst;
  word_t imem_addr;
  word_t imem_data;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  word_t wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0] wb_sel;

  word_t imem [0:255];
  word_t dmem [0:255];
  int n_inst;
  int store_off;
  int store_idx;
  string exp_name [$];
  word_t exp_adr [$];
  word_t exp_dat [$];
  logic [3:0] exp_sel [$];

  integer seed;
  int rnd;
  int cycles;
  logic [1:0] wait_left;
  word_t link_pc;

  rv_core uut (.*);

  assign imem_data = imem[imem_addr[9:2]]; // same-cycle fetch

  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic word_t enc_s(input int imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(input int imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_u(input int imm20, input int rd, input logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input string field,
                                input word_t expected, input word_t actual);
    $display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic emit(input word_t w);
    imem[n_inst] = w;
    n_inst++;
  endtask

  task automatic expect_store(input string name, input word_t adr, input word_t dat,
                              input logic [3:0] sel);
    exp_name.push_back(name);
    exp_adr.push_back(adr);
    exp_dat.push_back(dat);
    exp_sel.push_back(sel);
  endtask

  // sw rs into the next result slot at x10
  task automatic check_reg(input string name, input int rs, input word_t value);
    emit(enc_s(store_off, rs, 10, F3_WORD));
    expect_store(name, 32'h100 + store_off, value, 4'b1111);
    store_off += 4;
  endtask

  task automatic op_test(input string name, input word_t inst, input word_t value);
    emit(inst);
    check_reg(name, 3, value);
  endtask

  // never executed when control flow is right
  task automatic skipped_store();
    emit(enc_s('h3f0, 7, 0, F3_WORD));
  endtask

  task automatic branch_test(input string name, input logic [2:0] f3, input int rs1,
                             input int rs2, input logic taken);
    emit(enc_b(8, rs2, rs1, f3));
    if (taken) begin
      skipped_store();
    end else begin
      check_reg(name, 7, 32'h123);
    end
  endtask

  task automatic build_program();
    emit(enc_i(256, 0, 3'b000, 10, OP_IMM)); // result area
    emit(enc_i(-20, 0, 3'b000, 1, OP_IMM));
    emit(enc_i(7, 0, 3'b000, 2, OP_IMM));
    emit(enc_i(512, 0, 3'b000, 11, OP_IMM)); // byte area
    emit(enc_i('h123, 0, 3'b000, 7, OP_IMM)); // branch marker

    op_test("add", enc_r(7'h00, 2, 1, 3'b000, 3), 32'hffff_fff3);
    op_test("sub", enc_r(7'h20, 1, 2, 3'b000, 3), 32'h0000_001b);
    op_test("sll", enc_r(7'h00, 2, 2, 3'b001, 3), 32'h0000_0380);
    op_test("srl", enc_r(7'h00, 2, 1, 3'b101, 3), 32'h01ff_ffff);
    op_test("sra", enc_r(7'h20, 2, 1, 3'b101, 3), 32'hffff_ffff);
    op_test("and", enc_r(7'h00, 2, 1, 3'b111, 3), 32'h0000_0004);
    op_test("or", enc_r(7'h00, 2, 1, 3'b110, 3), 32'hffff_ffef);
    op_test("xor", enc_r(7'h00, 2, 1, 3'b100, 3), 32'hffff_ffeb);
    op_test("slt", enc_r(7'h00, 2, 1, 3'b010, 3), 32'h1);
    op_test("sltu", enc_r(7'h00, 2, 1, 3'b011, 3), 32'h0);
    op_test("addi", enc_i(100, 1, 3'b000, 3, OP_IMM), 32'h50);
    op_test("slli", enc_i(4, 2, 3'b001, 3, OP_IMM), 32'h70);
    op_test("srli", enc_i(4, 1, 3'b101, 3, OP_IMM), 32'h0fff_fffe);
    op_test("srai", enc_i('h402, 1, 3'b101, 3, OP_IMM), 32'hffff_fffb);
    op_test("andi", enc_i('h0f0, 1, 3'b111, 3, OP_IMM), 32'he0);
    op_test("ori", enc_i('h100, 2, 3'b110, 3, OP_IMM), 32'h107);
    op_test("xori", enc_i(-1, 1, 3'b100, 3, OP_IMM), 32'h13);
    op_test("slti", enc_i(-19, 1, 3'b010, 3, OP_IMM), 32'h1);
    op_test("sltiu", enc_i(-1, 2, 3'b011, 3, OP_IMM), 32'h1);
    op_test("lui", enc_u('h12345, 3, OP_LUI), 32'h1234_5000);
    op_test("auipc", enc_u('h00001, 3, OP_AUIPC), n_inst * 4 + 32'h1000);

    emit(enc_u('h12345, 5, OP_LUI));
    emit(enc_i('h678, 5, 3'b000, 5, OP_IMM));
    emit(enc_s(0, 5, 11, F3_WORD));
    expect_store("sw word", 32'h200, 32'h1234_5678, 4'b1111);
    emit(enc_i(0, 11, F3_WORD, 5, OP_LOAD));
    check_reg("lw", 5, 32'h1234_5678);
    emit(enc_i(-91, 0, 3'b000, 4, OP_IMM)); // low byte a5
    emit(enc_i('h7e, 0, 3'b000, 6, OP_IMM));
    emit(enc_s(0, 6, 11, F3_BYTE));
    expect_store("sb lane 0", 32'h200, 32'h0000_007e, 4'b0001);
    emit(enc_s(1, 4, 11, F3_BYTE));
    expect_store("sb lane 1", 32'h200, 32'h0000_a500, 4'b0010);
    emit(enc_s(2, 1, 11, F3_BYTE));
    expect_store("sb lane 2", 32'h200, 32'h00ec_0000, 4'b0100);
    emit(enc_s(3, 6, 11, F3_BYTE));
    expect_store("sb lane 3", 32'h200, 32'h7e00_0000, 4'b1000);
    emit(enc_i(0, 11, F3_WORD, 5, OP_LOAD));
    check_reg("lw after sb", 5, 32'h7eec_a57e);
    emit(enc_i(1, 11, F3_BYTE, 5, OP_LOAD));
    check_reg("lb negative", 5, 32'hffff_ffa5);
    emit(enc_i(3, 11, F3_BYTE, 5, OP_LOAD));
    check_reg("lb positive", 5, 32'h0000_007e);

    branch_test("beq taken", BR_EQ, 2, 2, 1'b1);
    branch_test("beq not taken", BR_EQ, 1, 2, 1'b0);
    branch_test("bne taken", BR_NE, 1, 2, 1'b1);
    branch_test("bne not taken", BR_NE, 2, 2, 1'b0);
    branch_test("blt taken", BR_LT, 1, 2, 1'b1);
    branch_test("blt not taken", BR_LT, 2, 1, 1'b0);
    branch_test("bge taken", BR_GE, 2, 1, 1'b1);
    branch_test("bge not taken", BR_GE, 1, 2, 1'b0);
    branch_test("bltu taken", BR_LTU, 2, 1, 1'b1);
    branch_test("bltu not taken", BR_LTU, 1, 2, 1'b0);
    branch_test("bgeu taken", BR_GEU, 1, 2, 1'b1);
    branch_test("bgeu not taken", BR_GEU, 2, 1, 1'b0);

    link_pc = n_inst * 4;
    emit(enc_j(8, 8));
    skipped_store();
    check_reg("jal link", 8, link_pc + 4);
    emit(enc_u(0, 9, OP_AUIPC));
    link_pc = n_inst * 4;
    emit(enc_i(13, 9, 3'b000, 8, OP_JALR)); // odd offset, lands on x9 + 12
    skipped_store();
    check_reg("jalr link", 8, link_pc + 4);
    emit(enc_j(0, 0)); // park here
  endtask

  task automatic check_store(input word_t adr, input word_t dat, input logic [3:0] sel);
    word_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    assert (store_idx < exp_adr.size())
      else stop_fail($sformatf("unexpected store of %h to address %h", dat, adr));
    assert (adr == exp_adr[store_idx])
      else value_mismatch(exp_name[store_idx], "address", exp_adr[store_idx], adr);
    assert (sel == exp_sel[store_idx])
      else value_mismatch(exp_name[store_idx], "sel", {28'd0, exp_sel[store_idx]}, {28'd0, sel});
    assert ((dat & mask) == exp_dat[store_idx])
      else value_mismatch(exp_name[store_idx], "data", exp_dat[store_idx], dat & mask);
    store_idx++;
  endtask

  task automatic write_lanes(input word_t adr, input word_t dat, input logic [3:0] sel);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        dmem[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // wishbone slave with 0 to 3 wait cycles
  always @(posedge clk) begin
    if (!rst) begin
      if (wb_ack) begin
        wb_ack <= 1'b0;
        rnd = $random(seed);
        wait_left <= rnd[1:0];
      end else if (wb_cyc && wb_stb) begin
        if (wait_left != 2'd0) begin
          wait_left <= wait_left - 2'd1;
        end else begin
          wb_ack <= 1'b1;
          if (wb_we) begin
            check_store(wb_adr, wb_dat_w, wb_sel);
            write_lanes(wb_adr, wb_dat_w, wb_sel);
          end else begin
            wb_dat_r <= dmem[wb_adr[9:2]];
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    assert (uut.props.err_count == 0)
      else stop_fail("a bound Wishbone or reset property failed");
  end

  initial begin
    seed = 32'he746;
    rst = 1'b1;
    wb_ack = 1'b0;
    wb_dat_r = '0;
    wait_left = 2'd0;
    n_inst = 0;
    store_off = 0;
    store_idx = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(i, 0, 3'b000, 0, OP_IMM); // addi x0, x0, i
      dmem[i] = 32'h9e37_79b9 * (i + 1);
    end
    build_program();

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    cycles = 0;
    while (store_idx < exp_adr.size() && cycles < 4000) begin
      @(posedge clk);
      cycles++;
    end
    repeat (8) @(posedge clk); // extra stores would show up here

    if (store_idx == exp_adr.size()) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_fail("timeout waiting for the final store");
    end
  end

endmodule

`default_nettype wire
